// ==== hw/mac_config.svh ====
// ##########################################################
// frame and register constants shared by the MAC blocks
// residue is the non-reflected lfsr value after a good FCS
// ##########################################################
`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

`define MAC_PREAMBLE_LEN 7
`define MAC_MIN_PAYLOAD  60
`define MAC_MIN_FRAME    64
`define MAC_IPG_DEFAULT  12
`define MAC_CRC_RESIDUE  32'hC704DD7B
`define MAC_WB_AW        5

`endif

// ==== hw/mac_frame_pkg.sv ====
// ##########################################################
// framer and checker state encodings and framing bytes
// state names carry a TX_/RX_ prefix to keep them apart
// ##########################################################
package mac_frame_pkg;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_SFD,
        TX_DATA,
        TX_PAD,
        TX_FCS,
        TX_GAP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA,
        RX_DONE
    } rx_state_t;

    localparam logic [7:0] MAC_SFD_BYTE = 8'hD5;
    localparam logic [7:0] MAC_PRE_BYTE = 8'h55;

endpackage

// ==== hw/mac_reg_pkg.sv ====
// ##########################################################
// register map and Wishbone-side types, 32-bit data bus
// ##########################################################
`include "mac_config.svh"

package mac_reg_pkg;

    typedef logic [31:0] wb_data_t;

    typedef enum logic [`MAC_WB_AW-1:0] {
        REG_CTRL      = 'h00,
        REG_IPG       = 'h04,
        REG_TX_FRAMES = 'h08,
        REG_RX_GOOD   = 'h0C,
        REG_RX_BAD    = 'h10
    } reg_addr_t;

    // first member lands in the msb
    typedef struct packed {
        logic pad_enable;
        logic rx_enable;
        logic tx_enable;
    } ctrl_reg_t;

endpackage

// ==== hw/mac_ctrl_if.sv ====
// ##########################################################
// control and event signals between registers and datapath
// event lines are single-cycle pulses
// ##########################################################
`timescale 1ns/1ps

interface mac_ctrl_if;
    import mac_reg_pkg::*;

    ctrl_reg_t  ctrl;
    logic [7:0] ipg;
    logic       tx_done;
    logic       rx_good;
    logic       rx_bad;

    modport regs (
        output ctrl, ipg,
        input  tx_done, rx_good, rx_bad
    );

    modport tx (input ctrl, ipg, output tx_done);

    modport rx (input ctrl, output rx_good, rx_bad);

endinterface

// ==== hw/mac_crc.sv ====
// ##########################################################
// byte-wise CRC-32 (0x04C11DB7), non-reflected register
// data_in is taken lsb first, as it goes on the wire
// init reloads all ones and wins over crc_en
// ##########################################################
`timescale 1ns/1ps

module mac_crc (
    input  logic        clk,
    input  logic        rst,
    input  logic        init,
    input  logic [7:0]  data_in,
    input  logic        crc_en,
    output logic [31:0] crc_out
);

    localparam logic [31:0] POLY = 32'h04C1_1DB7;

    logic [31:0] lfsr_q;
    logic [31:0] lfsr_c;

    assign crc_out = lfsr_q;

    // eight serial steps unrolled, bit 0 first
    always_comb begin
        lfsr_c = lfsr_q;
        for (int i = 0; i < 8; i++) begin
            if (lfsr_c[31] ^ data_in[i]) begin
                lfsr_c = {lfsr_c[30:0], 1'b0} ^ POLY;
            end else begin
                lfsr_c = {lfsr_c[30:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || init) begin
            lfsr_q <= '1;
        end else if (crc_en) begin
            lfsr_q <= lfsr_c;
        end
    end

endmodule

// ==== hw/mac_tx_framer.sv ====
// ##########################################################
// transmit framer: preamble, SFD, payload, pad, FCS, gap
// source must not drop tx_valid inside a frame
// gap is ipg cycles plus one idle cycle, at least one
// ##########################################################
`timescale 1ns/1ps
`include "mac_config.svh"

module mac_tx_framer (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    input  logic       tx_last,
    output logic       tx_ready,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    mac_ctrl_if.tx     ctrl
);
    import mac_frame_pkg::*;

    tx_state_t   state;
    logic [7:0]  cnt;
    logic        take;
    logic        pad_short;
    logic [7:0]  crc_data;
    logic        crc_en;
    logic [31:0] crc_out;
    logic [31:0] fcs_word;
    logic [7:0]  fcs_sel;
    logic [7:0]  fcs_byte;

    assign tx_ready  = (state == TX_DATA);
    assign take      = tx_valid && tx_ready;
    // cnt holds bytes sent before the one with tx_last
    assign pad_short = ctrl.ctrl.pad_enable && (cnt < 8'(`MAC_MIN_PAYLOAD - 1));

    assign crc_data = (state == TX_DATA) ? tx_data : 8'h00;
    assign crc_en   = take || (state == TX_PAD);

    // fcs goes out from bit 31 down, each byte lsb first
    assign fcs_word = ~crc_out;
    assign fcs_sel  = fcs_word[5'd31 - {cnt[1:0], 3'b000} -: 8];
    assign fcs_byte = {<<{fcs_sel}};

    mac_crc u_crc (
        .clk     (clk),
        .rst     (rst),
        .init    (state == TX_IDLE),
        .data_in (crc_data),
        .crc_en  (crc_en),
        .crc_out (crc_out)
    );

    always_comb begin
        gmii_tx_en = (state != TX_IDLE) && (state != TX_GAP);
        case (state)
            TX_PREAMBLE: gmii_txd = MAC_PRE_BYTE;
            TX_SFD:      gmii_txd = MAC_SFD_BYTE;
            TX_DATA:     gmii_txd = tx_data;
            TX_FCS:      gmii_txd = fcs_byte;
            default:     gmii_txd = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= TX_IDLE;
            cnt          <= '0;
            ctrl.tx_done <= 1'b0;
        end else begin
            ctrl.tx_done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (ctrl.ctrl.tx_enable && tx_valid) begin
                        state <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    cnt <= cnt + 8'd1;
                    if (cnt == 8'(`MAC_PREAMBLE_LEN - 1)) begin
                        state <= TX_SFD;
                    end
                end
                TX_SFD: begin
                    cnt   <= '0;
                    state <= TX_DATA;
                end
                TX_DATA: begin
                    if (take) begin
                        cnt <= (cnt == 8'hFF) ? cnt : cnt + 8'd1;
                        if (tx_last && pad_short) begin
                            state <= TX_PAD;
                        end else if (tx_last) begin
                            cnt   <= '0;
                            state <= TX_FCS;
                        end
                    end
                end
                TX_PAD: begin
                    cnt <= cnt + 8'd1;
                    if (cnt == 8'(`MAC_MIN_PAYLOAD - 1)) begin
                        cnt   <= '0;
                        state <= TX_FCS;
                    end
                end
                TX_FCS: begin
                    cnt <= cnt + 8'd1;
                    if (cnt == 8'd3) begin
                        cnt          <= '0;
                        ctrl.tx_done <= 1'b1;
                        state        <= TX_GAP;
                    end
                end
                default: begin
                    cnt <= cnt + 8'd1;
                    if (cnt + 8'd1 >= ctrl.ipg) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        (take && !tx_last) |=> tx_valid);

    // no new frame right after the one that raised tx_done
    a_gap_quiet: assert property (@(posedge clk) disable iff (rst)
        ctrl.tx_done |=> !gmii_tx_en);

endmodule

// ==== hw/mac_rx_checker.sv ====
// ##########################################################
// receive checker: strips preamble, checks FCS and length
// no back-pressure, payload leaves 5 bytes behind the bus
// frames shorter than 5 bytes after SFD give no stream output
// ##########################################################
`timescale 1ns/1ps
`include "mac_config.svh"

module mac_rx_checker (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       rx_last,
    output logic       rx_error,
    mac_ctrl_if.rx     ctrl
);
    import mac_frame_pkg::*;

    // four FCS bytes plus one to see the end of frame
    localparam int DLY_LEN = 5;

    rx_state_t   state;
    logic [7:0]  dly [DLY_LEN];
    logic [11:0] cnt;
    logic        crc_en;
    logic [31:0] crc_out;
    logic        held;
    logic        frame_ok;

    assign crc_en   = (state == RX_DATA) && gmii_rx_dv;
    assign held     = (cnt >= 12'(DLY_LEN));
    assign frame_ok = (crc_out == `MAC_CRC_RESIDUE) && (cnt >= 12'(`MAC_MIN_FRAME));

    mac_crc u_crc (
        .clk     (clk),
        .rst     (rst),
        .init    (state != RX_DATA),
        .data_in (gmii_rxd),
        .crc_en  (crc_en),
        .crc_out (crc_out)
    );

    always_ff @(posedge clk) begin
        if (crc_en) begin
            dly[0] <= gmii_rxd;
            for (int i = 1; i < DLY_LEN; i++) begin
                dly[i] <= dly[i-1];
            end
        end
        rx_data <= dly[DLY_LEN-1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= RX_IDLE;
            cnt          <= '0;
            rx_valid     <= 1'b0;
            rx_last      <= 1'b0;
            rx_error     <= 1'b0;
            ctrl.rx_good <= 1'b0;
            ctrl.rx_bad  <= 1'b0;
        end else begin
            rx_valid     <= 1'b0;
            rx_last      <= 1'b0;
            rx_error     <= 1'b0;
            ctrl.rx_good <= 1'b0;
            ctrl.rx_bad  <= 1'b0;
            case (state)
                RX_IDLE, RX_PREAMBLE: begin
                    cnt <= '0;
                    if (!gmii_rx_dv) begin
                        state <= RX_IDLE;
                    end else if (state == RX_IDLE && !ctrl.ctrl.rx_enable) begin
                        state <= RX_IDLE;
                    end else if (gmii_rxd == MAC_SFD_BYTE) begin
                        state <= RX_DATA;
                    end else if (gmii_rxd == MAC_PRE_BYTE) begin
                        state <= RX_PREAMBLE;
                    end else begin
                        state <= RX_DONE;
                    end
                end
                RX_DATA: begin
                    if (gmii_rx_dv) begin
                        cnt      <= (cnt == '1) ? cnt : cnt + 12'd1;
                        rx_valid <= held;
                    end else begin
                        state        <= RX_IDLE;
                        rx_valid     <= held;
                        rx_last      <= held;
                        rx_error     <= held && !frame_ok;
                        ctrl.rx_good <= frame_ok;
                        ctrl.rx_bad  <= !frame_ok;
                    end
                end
                default: begin
                    // broken preamble, drop the rest
                    if (!gmii_rx_dv) begin
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // a started stream runs without gaps up to its rx_last
    a_stream_contiguous: assert property (@(posedge clk) disable iff (rst)
        (rx_valid && !rx_last) |=> rx_valid);

endmodule

// ==== hw/mac_regs.sv ====
// ##########################################################
// Wishbone classic slave, single-cycle ack, no bursts
// unmapped reads return zero; any write clears a counter
// frame counters saturate at all ones
// ##########################################################
`timescale 1ns/1ps
`include "mac_config.svh"

module mac_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`MAC_WB_AW-1:0] wb_adr,
    input  mac_reg_pkg::wb_data_t wb_dat_w,
    output mac_reg_pkg::wb_data_t wb_dat_r,
    output logic                  wb_ack,
    mac_ctrl_if.regs              ctrl
);
    import mac_reg_pkg::*;

    localparam int NUM_CNT = 3;

    reg_addr_t          addr;
    logic               access;
    logic               wr;
    logic [NUM_CNT-1:0] evt;
    logic [NUM_CNT-1:0] clr;
    wb_data_t           frame_cnt [NUM_CNT];

    assign addr   = reg_addr_t'(wb_adr);
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr     = access && wb_we;

    // counter order: tx frames, rx good, rx bad
    assign evt = {ctrl.rx_bad, ctrl.rx_good, ctrl.tx_done};
    assign clr = {wr && (addr == REG_RX_BAD),
                  wr && (addr == REG_RX_GOOD),
                  wr && (addr == REG_TX_FRAMES)};

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            ctrl.ctrl <= '0;
            ctrl.ipg  <= 8'(`MAC_IPG_DEFAULT);
        end else begin
            wb_ack <= access;
            if (wr && addr == REG_CTRL) begin
                ctrl.ctrl <= ctrl_reg_t'(wb_dat_w[$bits(ctrl_reg_t)-1:0]);
            end
            if (wr && addr == REG_IPG) begin
                ctrl.ipg <= wb_dat_w[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (rst || clr[i]) begin
                frame_cnt[i] <= '0;
            end else if (evt[i] && frame_cnt[i] != '1) begin
                frame_cnt[i] <= frame_cnt[i] + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (addr)
                REG_CTRL:      wb_dat_r <= {29'd0, ctrl.ctrl};
                REG_IPG:       wb_dat_r <= {24'd0, ctrl.ipg};
                REG_TX_FRAMES: wb_dat_r <= frame_cnt[0];
                REG_RX_GOOD:   wb_dat_r <= frame_cnt[1];
                REG_RX_BAD:    wb_dat_r <= frame_cnt[2];
                default:       wb_dat_r <= '0;
            endcase
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack);

endmodule

// ==== hw/mac_top.sv ====
// ##########################################################
// MAC datapath top: Wishbone registers, framer and checker
// single clock domain, no buffering on either path
// ##########################################################
`timescale 1ns/1ps
`include "mac_config.svh"

module mac_top (
    input  logic                  clk,
    input  logic                  rst,
    // register bus
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`MAC_WB_AW-1:0] wb_adr,
    input  mac_reg_pkg::wb_data_t wb_dat_w,
    output mac_reg_pkg::wb_data_t wb_dat_r,
    output logic                  wb_ack,
    // transmit stream
    input  logic [7:0]            tx_data,
    input  logic                  tx_valid,
    input  logic                  tx_last,
    output logic                  tx_ready,
    // GMII
    output logic [7:0]            gmii_txd,
    output logic                  gmii_tx_en,
    input  logic [7:0]            gmii_rxd,
    input  logic                  gmii_rx_dv,
    // receive stream
    output logic [7:0]            rx_data,
    output logic                  rx_valid,
    output logic                  rx_last,
    output logic                  rx_error
);

    mac_ctrl_if ctrl_bus ();

    mac_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ctrl     (ctrl_bus.regs)
    );

    mac_tx_framer u_tx (
        .clk        (clk),
        .rst        (rst),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_last    (tx_last),
        .tx_ready   (tx_ready),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .ctrl       (ctrl_bus.tx)
    );

    mac_rx_checker u_rx (
        .clk        (clk),
        .rst        (rst),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_last    (rx_last),
        .rx_error   (rx_error),
        .ctrl       (ctrl_bus.rx)
    );

endmodule

// ==== test/tb_mac_top.sv ====
// ##########################################################
// loopback testbench, gmii_txd feeds gmii_rxd directly
// one bit of one byte can be flipped on the way back
// outputs sampled on the falling edge
// ##########################################################
`timescale 1ns/1ps
`include "mac_config.svh"

module tb_mac_top;
    import mac_reg_pkg::*;

    localparam int WAIT_LIMIT = 4000;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`MAC_WB_AW-1:0] wb_adr;
    logic [31:0]           wb_dat_w;
    logic [31:0]           wb_dat_r;
    logic                  wb_ack;
    logic [7:0]            tx_data;
    logic                  tx_valid;
    logic                  tx_last;
    logic                  tx_ready;
    logic [7:0]            gmii_txd;
    logic                  gmii_tx_en;
    logic [7:0]            gmii_rxd;
    logic                  gmii_rx_dv;
    logic [7:0]            rx_data;
    logic                  rx_valid;
    logic                  rx_last;
    logic                  rx_error;

    int          seed = 32'hd84666b2;
    // model state: expected bus bytes, frame lengths, stream items
    logic [7:0]  exp_bus [$];
    int          exp_len [$];
    logic [8:0]  exp_rx [$];
    bit          exp_err [$];
    int          cnt_tx;
    int          cnt_good;
    int          cnt_bad;
    logic [2:0]  ctrl_val;
    int          cur_ipg;
    bit          corrupt_on;
    int          corrupt_pos;
    logic [7:0]  corrupt_mask;
    int          tx_pos = 0;
    bit          was_en;
    bit          frames_seen;
    int          run_len;
    int          idle_run;
    logic [8:0]  rx_item;
    logic [31:0] rdata;

    mac_top UUT (.*);

    assign gmii_rxd   = gmii_txd ^ ((corrupt_on && tx_pos == corrupt_pos) ? corrupt_mask : 8'h00);
    assign gmii_rx_dv = gmii_tx_en;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // index of the byte now on the bus
    always @(posedge clk) begin
        tx_pos <= gmii_tx_en ? tx_pos + 1 : 0;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %0h actual %0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wb_access(input logic [`MAC_WB_AW-1:0] addr, input bit we,
                             input logic [31:0] data, output logic [31:0] rd);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = data;
        while (1) begin
            @(negedge clk);
            if (wb_ack) break;
            waited++;
            if (waited > 20) abort_run("register bus never acknowledged the access");
        end
        rd = wb_dat_r;
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [`MAC_WB_AW-1:0] addr,
                              input logic [31:0] expected);
        logic [31:0] rd;
        wb_access(addr, 1'b0, 32'd0, rd);
        check_value(name, expected, rd);
    endtask

    task automatic set_ctrl(input logic [2:0] v);
        wb_access(REG_CTRL, 1'b1, {29'd0, v}, rdata);
        ctrl_val = v;
    endtask

    task automatic check_counters();
        read_check("tx_frames", REG_TX_FRAMES, cnt_tx);
        read_check("rx_good", REG_RX_GOOD, cnt_good);
        read_check("rx_bad", REG_RX_BAD, cnt_bad);
    endtask

    // reflected CRC-32, result already complemented
    function automatic logic [31:0] fcs_of(input logic [7:0] data[$]);
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        foreach (data[i]) begin
            crc = crc ^ {24'd0, data[i]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    function automatic int rand_len(input int span);
        return 1 + int'(($random(seed) & 32'h7FFF_FFFF) % span);
    endfunction

    task automatic send_frame(input int len, input bit corrupt);
        logic [7:0]  body [$];
        logic [7:0]  flip;
        logic [31:0] fcs;
        int          waited;
        bit          err;
        for (int i = 0; i < len; i++) begin
            body.push_back(8'($random(seed)));
        end
        while (ctrl_val[2] && body.size() < `MAC_MIN_PAYLOAD) begin
            body.push_back(8'h00);
        end
        fcs = fcs_of(body);
        for (int i = 0; i < `MAC_PREAMBLE_LEN; i++) begin
            exp_bus.push_back(8'h55);
        end
        exp_bus.push_back(8'hD5);
        foreach (body[i]) begin
            exp_bus.push_back(body[i]);
        end
        for (int k = 0; k < 4; k++) begin
            exp_bus.push_back(fcs[8*k +: 8]);
        end
        exp_len.push_back(`MAC_PREAMBLE_LEN + 1 + body.size() + 4);
        // flipped bit lands in payload, pad or FCS, never the preamble
        corrupt_pos  = 8 + int'(($random(seed) & 32'h7FFF_FFFF) % (body.size() + 4));
        corrupt_mask = 8'(1 << ($random(seed) & 7));
        corrupt_on   = corrupt;
        err = corrupt || (body.size() + 4 < `MAC_MIN_FRAME);
        if (ctrl_val[1]) begin
            foreach (body[i]) begin
                flip = (corrupt && i + 8 == corrupt_pos) ? corrupt_mask : 8'h00;
                exp_rx.push_back({i == body.size() - 1, body[i] ^ flip});
            end
            exp_err.push_back(err);
            if (err) begin
                cnt_bad++;
            end else begin
                cnt_good++;
            end
        end
        cnt_tx++;
        @(posedge clk);
        #2;
        for (int i = 0; i < len; i++) begin
            tx_data  = body[i];
            tx_valid = 1'b1;
            tx_last  = (i == len - 1);
            waited   = 0;
            while (1) begin
                @(negedge clk);
                if (tx_ready) break;
                waited++;
                if (waited > WAIT_LIMIT) abort_run("framer never accepted a payload byte");
            end
            @(posedge clk);
            #2;
        end
        tx_valid = 1'b0;
        tx_last  = 1'b0;
    endtask

    task automatic wait_frame_done();
        int waited;
        waited = 0;
        while (exp_len.size() != 0 || exp_rx.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("frame did not finish on the bus and stream");
        end
        corrupt_on = 1'b0;
    endtask

    // transmit bus monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (gmii_tx_en) begin
                if (!was_en && frames_seen) begin
                    check_value("gap_at_least_ipg", 32'd1, 32'(idle_run >= cur_ipg));
                end
                if (exp_bus.size() == 0) abort_run("unexpected byte on the transmit bus");
                check_value("bus_byte", 32'(exp_bus.pop_front()), 32'(gmii_txd));
                run_len  = was_en ? run_len + 1 : 1;
                idle_run = 0;
            end else begin
                if (was_en) begin
                    if (exp_len.size() == 0) abort_run("transmit frame ended unexpectedly");
                    check_value("frame_len", exp_len.pop_front(), run_len);
                    frames_seen = 1'b1;
                end
                idle_run++;
            end
            was_en = gmii_tx_en;
        end
    end

    // receive stream monitor
    always @(negedge clk) begin
        if (!rst && rx_valid) begin
            if (exp_rx.size() == 0) abort_run("unexpected byte on the receive stream");
            rx_item = exp_rx.pop_front();
            check_value("rx_data", 32'(rx_item[7:0]), 32'(rx_data));
            check_value("rx_last", 32'(rx_item[8]), 32'(rx_last));
            if (rx_last) begin
                check_value("rx_error", 32'(exp_err.pop_front()), 32'(rx_error));
            end
        end
    end

    initial begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        tx_data  = '0;
        tx_valid = 1'b0;
        tx_last  = 1'b0;
        ctrl_val = '0;
        cur_ipg  = `MAC_IPG_DEFAULT;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        read_check("ctrl_reset", REG_CTRL, 32'd0);
        read_check("ipg_reset", REG_IPG, `MAC_IPG_DEFAULT);
        check_counters();
        set_ctrl(3'b111);
        read_check("ctrl_readback", REG_CTRL, 32'd7);
        wb_access(REG_IPG, 1'b1, 32'd16, rdata);
        cur_ipg = 16;
        read_check("ipg_readback", REG_IPG, 32'd16);
        read_check("unmapped_read", 5'h14, 32'd0);

        // padded random frames
        for (int n = 0; n < 12; n++) begin
            send_frame(rand_len(100), 1'b0);
            wait_frame_done();
        end
        check_counters();

        // single bit errors
        for (int n = 0; n < 4; n++) begin
            send_frame(rand_len(100), 1'b1);
            wait_frame_done();
        end
        check_counters();

        // no padding: short frames fail the length check
        set_ctrl(3'b011);
        for (int n = 0; n < 3; n++) begin
            send_frame(rand_len(59), 1'b0);
            wait_frame_done();
        end
        send_frame(60, 1'b0);
        wait_frame_done();
        send_frame(100, 1'b0);
        wait_frame_done();
        check_counters();

        // transmitter disabled with data waiting
        set_ctrl(3'b010);
        @(posedge clk);
        #2;
        tx_data  = 8'($random(seed));
        tx_valid = 1'b1;
        tx_last  = 1'b1;
        repeat (200) begin
            @(negedge clk);
            check_value("tx_ready_off", 32'd0, 32'(tx_ready));
            check_value("tx_en_off", 32'd0, 32'(gmii_tx_en));
        end
        @(posedge clk);
        #2;
        tx_valid = 1'b0;
        tx_last  = 1'b0;

        // receiver disabled, the stream monitor flags any output
        set_ctrl(3'b101);
        for (int n = 0; n < 2; n++) begin
            send_frame(rand_len(100), 1'b0);
            wait_frame_done();
        end
        check_counters();

        wb_access(REG_TX_FRAMES, 1'b1, 32'($random(seed)), rdata);
        wb_access(REG_RX_GOOD, 1'b1, 32'($random(seed)), rdata);
        wb_access(REG_RX_BAD, 1'b1, 32'($random(seed)), rdata);
        cnt_tx   = 0;
        cnt_good = 0;
        cnt_bad  = 0;
        check_counters();

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/mac_frame_pkg.sv
hw/mac_reg_pkg.sv
hw/mac_ctrl_if.sv
hw/mac_crc.sv
hw/mac_tx_framer.sv
hw/mac_rx_checker.sv
hw/mac_regs.sv
hw/mac_top.sv
test/tb_mac_top.sv

// ==== Makefile ====
# Verilator build of the MAC loopback testbench

SRCS := $(shell grep -v '^+' list.f) hw/mac_config.svh

all: run

obj_dir/Vtb_mac_top: list.f $(SRCS)
	verilator --binary --timing --assert -f list.f --top-module tb_mac_top -o Vtb_mac_top

run: obj_dir/Vtb_mac_top
	./obj_dir/Vtb_mac_top | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
